//--- fetch_fifo.sv
`include "prefetch_consts.svh"

module fetch_fifo
  import prefetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // Branch, empties the FIFO
  input  logic        flush_i,

  // Write side
  input  logic        push_i,
  input  fetch_resp_t push_data_i,
  output fetch_cnt_t  cnt_o,

  // Read side toward the fetch stage
  output logic        valid_o,
  input  logic        ready_i,
  output fetch_resp_t data_o
);

  localparam int         PTR_W     = $clog2(`PF_FIFO_DEPTH);
  localparam fetch_cnt_t DEPTH_CNT = fetch_cnt_t'(`PF_FIFO_DEPTH);

  // Storage
  fetch_resp_t      mem [`PF_FIFO_DEPTH];

  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  fetch_cnt_t       cnt_q;

  logic             push;
  logic             pop;

  // Pointer advance with wrap at the last entry
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`PF_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////////////////////

  assign valid_o = (cnt_q != '0);
  assign data_o  = mem[rd_ptr_q];
  assign cnt_o   = cnt_q;

  // Flush takes priority over both sides
  assign push = push_i && !flush_i;
  assign pop  = valid_o && ready_i && !flush_i;

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // Push with pop leaves the count alone
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Entry write
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Controller issue limit keeps a slot free for every response
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    push_i |-> (cnt_q < DEPTH_CNT)
  );

endmodule

//--- flist.f
+incdir+.
prefetch_pkg.sv
prefetch_controller.sv
obi_instr_port.sv
fetch_fifo.sv
prefetch_buffer.sv
tb_prefetch_buffer.sv

//--- obi_instr_port.sv
`include "prefetch_consts.svh"

module obi_instr_port
  import prefetch_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // Transaction request from the controller
  input  logic                  trans_valid_i,
  output logic                  trans_ready_o,
  input  fetch_trans_t          trans_i,

  // OBI address phase
  output logic                  bus_req_o,
  input  logic                  bus_gnt_i,
  output logic [`PF_ADDR_W-1:0] bus_addr_o
);

  // A request went out but has no grant yet
  logic         held_q;
  // Copy of that request
  fetch_trans_t held_trans_q;

  logic         capture;

  ////////////////////////////////////////////////////////////////////////////
  // Address phase drive
  ////////////////////////////////////////////////////////////////////////////

  // Held request wins, otherwise pass the controller straight through
  assign bus_req_o  = held_q ? 1'b1 : trans_valid_i;
  assign bus_addr_o = held_q ? held_trans_q.addr : trans_i.addr;

  // No new request while an old one waits for its grant
  assign trans_ready_o = !held_q;

  // Fresh request left ungranted, so freeze it
  assign capture = !held_q && trans_valid_i && !bus_gnt_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      held_q <= 1'b0;
    end else begin
      if (capture) begin
        held_q <= 1'b1;
      end else if (held_q && bus_gnt_i) begin
        held_q <= 1'b0;
      end
    end
  end

  // Payload copy
  always_ff @(posedge clk) begin
    if (capture) begin
      held_trans_q <= trans_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // OBI: an ungranted request stays up with the same address
  a_req_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (bus_req_o && !bus_gnt_i) |=> (bus_req_o && $stable(bus_addr_o))
  );

endmodule

//--- prefetch_buffer.sv
`include "prefetch_consts.svh"

module prefetch_buffer
  import prefetch_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // Fetch stage side
  input  logic                  req_i,
  input  logic                  branch_i,
  input  logic [`PF_ADDR_W-1:0] branch_addr_i,
  output logic                  busy_o,

  // Instruction output
  output logic                  instr_valid_o,
  input  logic                  instr_ready_i,
  output fetch_resp_t           instr_o,

  // OBI instruction bus
  output logic                  bus_req_o,
  input  logic                  bus_gnt_i,
  output logic [`PF_ADDR_W-1:0] bus_addr_o,
  input  logic                  bus_rvalid_i,
  input  logic [`PF_ADDR_W-1:0] bus_rdata_i,
  input  logic                  bus_err_i
);

  // Controller to bus port
  logic         trans_valid;
  logic         trans_ready;
  fetch_trans_t trans;

  // Response path into the FIFO
  fetch_resp_t  bus_resp;
  logic         fifo_push;
  fetch_cnt_t   fifo_cnt;

  // Response word as the FIFO stores it
  assign bus_resp.data = bus_rdata_i;
  assign bus_resp.err  = bus_err_i;

  ////////////////////////////////////////////////////////////////////////////
  // Loop of controller, bus port and FIFO
  ////////////////////////////////////////////////////////////////////////////

  prefetch_controller i_prefetch_controller (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .busy_o        (busy_o),
    .trans_valid_o (trans_valid),
    .trans_ready_i (trans_ready),
    .trans_o       (trans),
    .resp_valid_i  (bus_rvalid_i),
    .fifo_push_o   (fifo_push),
    .fifo_cnt_i    (fifo_cnt)
  );

  obi_instr_port i_obi_instr_port (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans_valid_i (trans_valid),
    .trans_ready_o (trans_ready),
    .trans_i       (trans),
    .bus_req_o     (bus_req_o),
    .bus_gnt_i     (bus_gnt_i),
    .bus_addr_o    (bus_addr_o)
  );

  // Branch empties the FIFO at the same edge the controller reloads
  fetch_fifo i_fetch_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (branch_i),
    .push_i      (fifo_push),
    .push_data_i (bus_resp),
    .cnt_o       (fifo_cnt),
    .valid_o     (instr_valid_o),
    .ready_i     (instr_ready_i),
    .data_o      (instr_o)
  );

endmodule

//--- prefetch_consts.svh
`ifndef PREFETCH_CONSTS_SVH
`define PREFETCH_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Prefetch subsystem sizing
////////////////////////////////////////////////////////////////////////////

// Fetch FIFO entries
// Also caps FIFO fill plus outstanding bus transactions
`define PF_FIFO_DEPTH 4

// Instruction address and data width
`define PF_ADDR_W 32

// Width of every count in the subsystem
// Must hold the values 0 up to PF_FIFO_DEPTH
`define PF_CNT_W 3

`endif

//--- prefetch_controller.sv
`include "prefetch_consts.svh"

module prefetch_controller
  import prefetch_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // Fetch stage side
  input  logic                  req_i,
  input  logic                  branch_i,
  input  logic [`PF_ADDR_W-1:0] branch_addr_i,
  output logic                  busy_o,

  // Transaction request toward the bus port
  output logic                  trans_valid_o,
  input  logic                  trans_ready_i,
  output fetch_trans_t          trans_o,

  // Response strobe from the bus
  input  logic                  resp_valid_i,

  // FIFO side
  output logic                  fifo_push_o,
  input  fetch_cnt_t            fifo_cnt_i
);

  // Depth as a count value
  localparam fetch_cnt_t DEPTH_CNT = fetch_cnt_t'(`PF_FIFO_DEPTH);

  // Branch replay FSM
  typedef enum logic {
    IDLE,
    BRANCH_WAIT
  } pf_state_e;

  pf_state_e             state_q;
  pf_state_e             state_d;

  // Outstanding transactions
  fetch_cnt_t            cnt_q;
  fetch_cnt_t            cnt_d;
  logic                  count_up;
  logic                  count_down;

  // Responses of the old stream still to be dropped
  fetch_cnt_t            flush_cnt_q;
  fetch_cnt_t            flush_cnt_d;

  // FIFO fill plus outstanding in one extra bit so it cannot wrap
  logic [`PF_CNT_W:0]    fill_sum;

  // Address state
  logic [`PF_ADDR_W-1:0] addr_q;
  logic [`PF_ADDR_W-1:0] addr_incr;
  logic [`PF_ADDR_W-1:0] addr_aligned;
  logic [`PF_ADDR_W-1:0] trans_addr;

  logic                  trans_accept;

  ////////////////////////////////////////////////////////////////////////////
  // Issue
  ////////////////////////////////////////////////////////////////////////////

  // Word fetches only
  assign addr_aligned = {branch_addr_i[`PF_ADDR_W-1:2], 2'b00};
  assign addr_incr    = addr_q + `PF_ADDR_W'(4);

  // Every accepted request must find a free FIFO slot
  assign fill_sum      = {1'b0, fifo_cnt_i} + {1'b0, cnt_q};
  assign trans_valid_o = req_i && (fill_sum < {1'b0, DEPTH_CNT});
  assign trans_accept  = trans_valid_o && trans_ready_i;

  // Busy while anything is offered or still on the bus
  assign busy_o = (cnt_q != '0) || trans_valid_o;

  assign trans_o.addr = trans_addr;

  // Address select and branch replay
  always_comb begin
    state_d    = state_q;
    trans_addr = addr_q;
    unique case (state_q)
      IDLE: begin
        // Branch target goes out in the branch cycle itself
        trans_addr = branch_i ? addr_aligned : addr_incr;
        if (branch_i && !trans_accept) begin
          state_d = BRANCH_WAIT;
        end
      end
      BRANCH_WAIT: begin
        // Keep offering the stored target or a newer one
        trans_addr = branch_i ? addr_aligned : addr_q;
        if (trans_accept) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Responses and counters
  ////////////////////////////////////////////////////////////////////////////

  // Drop responses that belong to the stream before the branch
  assign fifo_push_o = resp_valid_i && !(branch_i || (flush_cnt_q != '0));

  assign count_up   = trans_accept;
  // On an in-order bus each response retires one transaction
  assign count_down = resp_valid_i;

  always_comb begin
    unique case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  // Load with outstanding count at a branch
  // FIFO contents are dropped in the FIFO itself
  always_comb begin
    flush_cnt_d = flush_cnt_q;
    if (branch_i) begin
      flush_cnt_d = cnt_q;
      if (resp_valid_i && (cnt_q != '0)) begin
        flush_cnt_d = cnt_q - 1'b1;
      end
    end else if (resp_valid_i && (flush_cnt_q != '0)) begin
      flush_cnt_d = flush_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      cnt_q       <= '0;
      flush_cnt_q <= '0;
      addr_q      <= '0;
    end else begin
      state_q     <= state_d;
      cnt_q       <= cnt_d;
      flush_cnt_q <= flush_cnt_d;
      // Remember the target at a branch and each accepted address
      if (branch_i || trans_accept) begin
        addr_q <= trans_addr;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Outstanding count stays within FIFO depth
  a_cnt_max: assert property (
    @(posedge clk) disable iff (!rst_n)
    cnt_q <= DEPTH_CNT
  );

endmodule

//--- prefetch_pkg.sv
`include "prefetch_consts.svh"

package prefetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Shared prefetch types
  ////////////////////////////////////////////////////////////////////////////

  // One transaction request from the controller to the bus port
  typedef struct packed {
    // Word aligned fetch address
    logic [`PF_ADDR_W-1:0] addr;
  } fetch_trans_t;

  // One response word from the instruction bus
  typedef struct packed {
    // Instruction word
    logic [`PF_ADDR_W-1:0] data;
    // Bus error, passed along to the fetch stage untouched
    logic                  err;
  } fetch_resp_t;

  // Counts of FIFO entries and outstanding transactions
  // Range 0 to PF_FIFO_DEPTH
  typedef logic [`PF_CNT_W-1:0] fetch_cnt_t;

endpackage

//--- tb_prefetch_buffer.sv
`include "prefetch_consts.svh"

module tb_prefetch_buffer
  import prefetch_pkg::*;
();

  localparam int          PERIOD  = 40;
  localparam int          DRV     = 5;
  localparam logic [31:0] PATTERN = 32'h5A3C_96E1;
  // Cycle limits of the tests summed for the watchdog
  localparam int RST_CYC = 10;
  localparam int IDLE_CYC = 60;
  localparam int SEQ_CYC = 100;
  localparam int BP_CYC = 300;
  localparam int FLIGHT_CYC = 200;
  localparam int BUDGET = RST_CYC + 5 + 3 * (IDLE_CYC + 2) + SEQ_CYC + BP_CYC
                        + 2 * FLIGHT_CYC + IDLE_CYC + 10;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic req_i = 1'b0;
  logic branch_i = 1'b0;
  logic [`PF_ADDR_W-1:0] branch_addr_i = '0;
  logic busy_o, instr_valid_o, bus_req_o;
  logic instr_ready_i = 1'b0;
  fetch_resp_t instr_o;
  logic bus_gnt_i = 1'b0;
  logic [`PF_ADDR_W-1:0] bus_addr_o;
  logic bus_rvalid_i = 1'b0;
  logic [`PF_ADDR_W-1:0] bus_rdata_i = '0;
  logic bus_err_i = 1'b0;

  // Bus model and scoreboard state
  logic [31:0] rng = 32'd80;
  logic [31:0] pend_q[$];
  logic [31:0] exp_addr = '0;
  int pend_cnt = 0;
  int resp_wait = 0;
  int issued = 0;
  int delivered = 0;
  // Test control
  bit stall_en, ready_rand, ready_block, idle_chk, room_chk, drain_chk;
  string test_name = "none";
  int err_cnt = 0;
  int err_base = 0;
  int tests_run = 0;

  prefetch_buffer i_prefetch_buffer (.*);

  always #(PERIOD / 2) clk = !clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // In-order bus memory model with data of address XOR a pattern
  ////////////////////////////////////////////////////////////////////////////

  always begin : bus_model
    logic        gnt_nxt;
    logic        rvalid_nxt;
    logic        ready_nxt;
    logic [31:0] rd_addr;
    @(posedge clk);
    if (bus_req_o && bus_gnt_i) begin
      pend_q.push_back(bus_addr_o);
      issued++;
    end
    // Delivered word moves the expected stream on by one word
    if (instr_valid_o && instr_ready_i) begin
      delivered++;
      exp_addr = exp_addr + 32'd4;
    end
    // Choices are made at the edge and driven after the delay
    rng = xorshift32(rng);
    gnt_nxt = !stall_en || (rng[1:0] != 2'b00);
    rvalid_nxt = 1'b0;
    rd_addr = '0;
    if (resp_wait != 0) begin
      resp_wait--;
    end else if (pend_q.size() != 0) begin
      rvalid_nxt = 1'b1;
      rd_addr = pend_q.pop_front();
      rng = xorshift32(rng);
      // Gap of 0 to 2 extra cycles before the next response
      resp_wait = rng % 3;
    end
    pend_cnt = pend_q.size();
    rng = xorshift32(rng);
    ready_nxt = !ready_block && (!ready_rand || (rng[3:2] != 2'b00));
    #DRV;
    bus_gnt_i = gnt_nxt;
    bus_rvalid_i = rvalid_nxt;
    if (rvalid_nxt) begin
      bus_rdata_i = rd_addr ^ PATTERN;
      // Error flag follows an address bit so both values show up
      bus_err_i = rd_addr[3];
    end
    instr_ready_i = ready_nxt;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
    idle_chk |-> (!bus_req_o && !instr_valid_o && !busy_o))
  else begin
    $display("CHECK FAILED %s expected 000 actual %b%b%b", test_name,
             $sampled(bus_req_o), $sampled(instr_valid_o), $sampled(busy_o));
    err_cnt++;
  end

  // Sequence check also catches lost, repeated and old stream words
  a_word: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_valid_o && instr_ready_i) |-> (instr_o.data == (exp_addr ^ PATTERN)))
  else begin
    $display("CHECK FAILED %s expected %h actual %h", test_name,
             $sampled(exp_addr) ^ PATTERN, $sampled(instr_o.data));
    err_cnt++;
  end

  // Error flag travels with its word
  a_err: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_valid_o && instr_ready_i) |-> (instr_o.err == exp_addr[3]))
  else begin
    $display("CHECK FAILED %s expected err %b actual err %b", test_name,
             $sampled(exp_addr[3]), $sampled(instr_o.err));
    err_cnt++;
  end

  a_room: assert property (@(posedge clk) disable iff (!rst_n)
    room_chk |-> ((issued - delivered) <= `PF_FIFO_DEPTH))
  else begin
    $display("In %s more words were granted than the FIFO can hold", test_name);
    err_cnt++;
  end

  a_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_req_o && !bus_gnt_i) |=> (bus_req_o && $stable(bus_addr_o)))
  else begin
    $display("In %s a stalled bus request dropped or changed address", test_name);
    err_cnt++;
  end

  a_drain: assert property (@(posedge clk) disable iff (!rst_n)
    drain_chk |-> (!bus_req_o && !busy_o && (pend_cnt == 0)))
  else begin
    $display("In %s the port was not idle after busy fell", test_name);
    err_cnt++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test steps
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_idle(input int limit);
    int cyc;
    cyc = 0;
    while (busy_o && (cyc < limit)) begin
      @(posedge clk);
      #DRV;
      cyc++;
    end
    if (busy_o) begin
      $display("Timeout in %s waiting for busy_o to fall", test_name);
      err_cnt++;
    end
  endtask

  // Ready held low in the branch cycle so no word is taken as it flushes
  task automatic do_branch(input logic [31:0] addr);
    ready_block = 1'b1;
    @(posedge clk);
    #DRV;
    branch_i = 1'b1;
    branch_addr_i = addr;
    req_i = 1'b1;
    exp_addr = {addr[31:2], 2'b00};
    issued = 0;
    delivered = 0;
    @(posedge clk);
    #DRV;
    branch_i = 1'b0;
    ready_block = 1'b0;
  endtask

  // Start a new stream from an idle bus
  task automatic start_stream(input string name, input logic [31:0] addr,
                              input bit stall, input bit rnd_ready);
    test_name = name;
    err_base = err_cnt;
    req_i = 1'b0;
    @(posedge clk);
    #DRV;
    wait_idle(IDLE_CYC);
    stall_en = stall;
    ready_rand = rnd_ready;
    do_branch(addr);
  endtask

  task automatic wait_words(input int n, input int limit);
    int cyc;
    cyc = 0;
    while ((delivered < n) && (cyc < limit)) begin
      @(posedge clk);
      #DRV;
      cyc++;
    end
    if (delivered < n) begin
      $display("Timeout in %s, %0d of %0d words delivered", test_name, delivered, n);
      err_cnt++;
    end
  endtask

  task automatic finish_test();
    $display("test %-16s done, %0d failed checks", test_name, err_cnt - err_base);
    tests_run++;
  endtask

  initial begin
    #(BUDGET * PERIOD + 100 * PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    repeat (RST_CYC) @(posedge clk);
    #DRV;
    rst_n = 1'b1;
    test_name = "reset_idle";
    idle_chk = 1'b1;
    repeat (5) @(posedge clk);
    #DRV;
    idle_chk = 1'b0;
    finish_test();
    // Unaligned target on a clean bus
    start_stream("sequential", 32'h0000_1002, 1'b0, 1'b0);
    wait_words(12, SEQ_CYC);
    finish_test();
    start_stream("backpressure", 32'h0000_2400, 1'b1, 1'b1);
    room_chk = 1'b1;
    wait_words(16, BP_CYC);
    room_chk = 1'b0;
    finish_test();
    // Branch once the old stream has granted words still unanswered
    test_name = "branch_in_flight";
    err_base = err_cnt;
    ready_rand = 1'b0;
    wait_words(delivered + 2, FLIGHT_CYC);
    while (pend_cnt == 0) begin
      @(posedge clk);
      #DRV;
    end
    do_branch(32'h0000_8007);
    wait_words(8, FLIGHT_CYC);
    finish_test();
    test_name = "drain";
    err_base = err_cnt;
    req_i = 1'b0;
    @(posedge clk);
    #DRV;
    wait_idle(IDLE_CYC);
    drain_chk = 1'b1;
    repeat (10) @(posedge clk);
    #DRV;
    drain_chk = 1'b0;
    finish_test();
    $display("tests run %0d, failed checks %0d", tests_run, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
